/* hdl/prf_cfg_pkg.sv */
//**************************************************************************
// Size and port-count constants of the physical register file.
// PR_AW must stay equal to clog2(PR_NUM), and register 0 is reserved
// as the constant zero register. Each instruction has two sources.
//**************************************************************************

`default_nettype none

package prf_cfg_pkg;

    // storage
    localparam int PR_NUM = 64;               // physical registers
    localparam int PR_AW  = $clog2(PR_NUM);   // 6 address bits
    localparam int DATA_W = 64;               // register value width

    // pipeline widths
    localparam int REN_W = 2;                 // rename slots per cycle
    localparam int ISS_W = 2;                 // issue slots per cycle
    localparam int EXE_W = 2;                 // write-back slots per cycle

    // sources per instruction, and the RAM read ports they need
    localparam int SRC_N = 2;
    localparam int RD_N  = SRC_N * ISS_W;

endpackage : prf_cfg_pkg

`default_nettype wire

/* hdl/pipe_bundle_pkg.sv */
//**************************************************************************
// Bundles exchanged between the pipeline stages and the register file.
// Every slot carries its own valid bit and none can stall.
// A faulting write-back (exc) still frees its busy bit but writes no data.
//**************************************************************************

`default_nettype none

package pipe_bundle_pkg;

    import prf_cfg_pkg::*;

    typedef logic [PR_AW-1:0]  preg_t;  // physical register address
    typedef logic [DATA_W-1:0] word_t;  // register value

    // one renamed instruction
    typedef struct packed {
        logic                  valid;
        preg_t [SRC_N-1:0]     prs;     // sources
        preg_t                 prd;     // freshly allocated destination
    } ren_bundle_t;

    // one issuing instruction
    typedef struct packed {
        logic                  valid;
        preg_t [SRC_N-1:0]     prs;
    } iss_bundle_t;

    // one write-back
    typedef struct packed {
        logic                  valid;
        logic                  exc;     // faulted, data is dropped
        preg_t                 prd;
        word_t                 data;
    } exe_bundle_t;

    // commit side
    typedef struct packed {
        logic                  redir;   // pipeline redirect
    } com_bundle_t;

    // busy answer for both sources of a rename slot
    typedef logic [SRC_N-1:0] busy_pair_t;

    // operand values for both sources of an issue slot
    typedef word_t [SRC_N-1:0] opnd_pair_t;

endpackage : pipe_bundle_pkg

`default_nettype wire

/* hdl/busy_table.sv */
//**************************************************************************
// One busy bit per physical register. The response is combinational and
// forwards sets from earlier slots of the same rename group as well as
// clears from same-cycle write-backs. A redirect empties the table on the
// edge and overrides any set or clear of that cycle.
//**************************************************************************

`default_nettype none

module busy_table
    import prf_cfg_pkg::*;
    import pipe_bundle_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  ren_bundle_t [REN_W-1:0]    ren,
    input  exe_bundle_t [EXE_W-1:0]    exe,
    input  logic                       redir,
    output busy_pair_t  [REN_W-1:0]    busy_resp
);

    logic [PR_NUM-1:0] busy_q;
    logic [PR_NUM-1:0] busy_d;

    // lookup with same-cycle forwarding
    always_comb begin
        for (int i = 0; i < REN_W; i++) begin
            for (int s = 0; s < SRC_N; s++) begin
                busy_resp[i][s] = busy_q[ren[i].prs[s]];

                // older slot in this group writes the source
                for (int j = 0; j < i; j++) begin
                    if (ren[j].valid && ren[j].prd == ren[i].prs[s]) begin
                        busy_resp[i][s] = 1'b1;
                    end
                end

                // result arrives this cycle
                for (int k = 0; k < EXE_W; k++) begin
                    if (exe[k].valid && exe[k].prd == ren[i].prs[s]) begin
                        busy_resp[i][s] = 1'b0;
                    end
                end

                if (ren[i].prs[s] == '0) begin
                    busy_resp[i][s] = 1'b0;  // zero reg is never waited on
                end
            end
        end
    end

    // next state, clears applied after sets so a clear wins
    always_comb begin
        busy_d = busy_q;
        for (int i = 0; i < REN_W; i++) begin
            if (ren[i].valid && ren[i].prd != '0) begin
                busy_d[ren[i].prd] = 1'b1;
            end
        end
        for (int k = 0; k < EXE_W; k++) begin
            if (exe[k].valid) begin
                busy_d[exe[k].prd] = 1'b0;  // exc clears too
            end
        end
        busy_d[0] = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else if (redir) begin
            busy_q <= '0;                    // redirect flushes everything
        end else begin
            busy_q <= busy_d;
        end
    end

endmodule : busy_table

`default_nettype wire

/* hdl/mwp_ram.sv */
//**************************************************************************
// Register storage with RD_N asynchronous read ports and EXE_W
// synchronous write ports. On an address clash between enabled write
// ports the highest-numbered port wins. Reset clears every word, and
// there is no read-during-write bypass here.
//**************************************************************************

`default_nettype none

module mwp_ram
    import prf_cfg_pkg::*;
    import pipe_bundle_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  preg_t [RD_N-1:0]        raddr,
    output word_t [RD_N-1:0]        rdata,
    input  preg_t [EXE_W-1:0]       waddr,
    input  word_t [EXE_W-1:0]       wdata,
    input  logic  [EXE_W-1:0]       wen
);

    word_t mem [PR_NUM];

    // asynchronous reads
    always_comb begin
        for (int r = 0; r < RD_N; r++) begin
            rdata[r] = mem[raddr[r]];
        end
    end

    // later ports overwrite earlier ones in the loop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int a = 0; a < PR_NUM; a++) begin
                mem[a] <= '0;
            end
        end else begin
            for (int p = 0; p < EXE_W; p++) begin
                if (wen[p]) begin
                    mem[waddr[p]] <= wdata[p];
                end
            end
        end
    end

endmodule : mwp_ram

`default_nettype wire

/* hdl/prf.sv */
//**************************************************************************
// Physical register file top level with busy table and register storage.
// Busy and operand responses are combinational in the request cycle.
// Operand reads see same-cycle write-backs, and the highest write port
// wins. Faulting or invalid write-backs and writes to register 0 are
// dropped before the storage.
//**************************************************************************

`default_nettype none

module prf
    import prf_cfg_pkg::*;
    import pipe_bundle_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  ren_bundle_t [REN_W-1:0]    ren,
    input  iss_bundle_t [ISS_W-1:0]    iss,
    input  exe_bundle_t [EXE_W-1:0]    exe,
    input  com_bundle_t                com,
    output busy_pair_t  [REN_W-1:0]    busy_resp,
    output opnd_pair_t  [ISS_W-1:0]    opnd_resp
);

    preg_t [RD_N-1:0]  raddr;
    word_t [RD_N-1:0]  rdata;
    preg_t [EXE_W-1:0] waddr;
    word_t [EXE_W-1:0] wdata;
    logic  [EXE_W-1:0] wen;

    busy_table busy_table_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ren       (ren),
        .exe       (exe),
        .redir     (com.redir),
        .busy_resp (busy_resp)
    );

    // issue sources, slot-major order
    always_comb begin
        for (int i = 0; i < ISS_W; i++) begin
            for (int s = 0; s < SRC_N; s++) begin
                raddr[i*SRC_N + s] = iss[i].prs[s];
            end
        end
    end

    // write ports from the write-back bundles
    always_comb begin
        for (int k = 0; k < EXE_W; k++) begin
            waddr[k] = exe[k].prd;
            wdata[k] = exe[k].data;
            wen[k]   = exe[k].valid && !exe[k].exc && (exe[k].prd != '0);
        end
    end

    mwp_ram mwp_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (raddr),
        .rdata (rdata),
        .waddr (waddr),
        .wdata (wdata),
        .wen   (wen)
    );

    // operand select with write-back bypass
    always_comb begin
        for (int i = 0; i < ISS_W; i++) begin
            for (int s = 0; s < SRC_N; s++) begin
                if (raddr[i*SRC_N + s] == '0) begin
                    opnd_resp[i][s] = '0;            // hardwired zero
                end else begin
                    opnd_resp[i][s] = rdata[i*SRC_N + s];
                    for (int k = 0; k < EXE_W; k++) begin
                        if (wen[k] && waddr[k] == raddr[i*SRC_N + s]) begin
                            opnd_resp[i][s] = wdata[k];  // last match wins
                        end
                    end
                end
            end
        end
    end

endmodule : prf

`default_nettype wire

/* bench/prf_assert.sv */
//**************************************************************************
// Concurrent checks bound into the register file top level.
// fail_cnt counts failing assertions and is read by the testbench.
// Checks hold whether or not a slot is valid.
//**************************************************************************

`default_nettype none

module prf_assert
    import prf_cfg_pkg::*;
    import pipe_bundle_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  ren_bundle_t [REN_W-1:0]    ren,
    input  iss_bundle_t [ISS_W-1:0]    iss,
    input  com_bundle_t                com,
    input  busy_pair_t  [REN_W-1:0]    busy_resp,
    input  opnd_pair_t  [ISS_W-1:0]    opnd_resp
);

    int fail_cnt = 0;

    // source written by an older valid slot of the same group
    function automatic logic group_hit(ren_bundle_t [REN_W-1:0] r, int i, int s);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < i; j++) begin
            if (r[j].valid && r[j].prd == r[i].prs[s]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    for (genvar i = 0; i < REN_W; i++) begin : g_ren
        for (genvar s = 0; s < SRC_N; s++) begin : g_src
            zero_never_busy: assert property (@(posedge clk) disable iff (!rst_n)
                ren[i].prs[s] == '0 |-> !busy_resp[i][s])
                else begin
                    $error("register 0 source reported busy in rename slot %0d", i);
                    fail_cnt++;
                end

            // table is empty after a redirect, only group forwarding remains
            redirect_empties: assert property (@(posedge clk) disable iff (!rst_n)
                $past(com.redir) && busy_resp[i][s] |-> group_hit(ren, i, s))
                else begin
                    $error("busy bit survived a redirect in rename slot %0d", i);
                    fail_cnt++;
                end
        end
    end

    for (genvar i = 0; i < ISS_W; i++) begin : g_iss
        for (genvar s = 0; s < SRC_N; s++) begin : g_src
            zero_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
                iss[i].prs[s] == '0 |-> opnd_resp[i][s] == '0)
                else begin
                    $error("register 0 operand not zero in issue slot %0d", i);
                    fail_cnt++;
                end
        end
    end

endmodule : prf_assert

bind prf prf_assert prf_assert_i (.*);

`default_nettype wire

/* bench/tb_prf.sv */
//**************************************************************************
// Random testbench for the physical register file. Addresses are drawn
// from a small hot range so that forwarding and port clashes are common.
// Inputs change on the rising edge, responses are compared on the
// falling edge against a busy and register model kept here.
//**************************************************************************

`default_nettype none

module tb_prf
    import prf_cfg_pkg::*;
    import pipe_bundle_pkg::*;
();

    localparam int RST_CYC  = 8;
    localparam int RUN_CYC  = 3000;
    localparam int TIMEOUT  = RST_CYC + RUN_CYC + 100;
    localparam int HOT_MASK = 7;                 // registers 0..7 only

    logic                       clk;
    logic                       rst_n;
    ren_bundle_t [REN_W-1:0]    ren;
    iss_bundle_t [ISS_W-1:0]    iss;
    exe_bundle_t [EXE_W-1:0]    exe;
    com_bundle_t                com;
    busy_pair_t  [REN_W-1:0]    busy_resp;
    opnd_pair_t  [ISS_W-1:0]    opnd_resp;

    logic  model_busy [PR_NUM];                  // reference busy table
    word_t model_reg  [PR_NUM];                  // reference register values

    integer seed;
    int     cycle_cnt = 0;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    prf prf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ren       (ren),
        .iss       (iss),
        .exe       (exe),
        .com       (com),
        .busy_resp (busy_resp),
        .opnd_resp (opnd_resp)
    );

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_busy(string name, busy_pair_t exp, busy_pair_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_opnd(string name, opnd_pair_t exp, opnd_pair_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    function automatic preg_t rand_preg();
        return preg_t'($random(seed) & HOT_MASK);
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w[63:32] = $random(seed);
        w[31:0]  = $random(seed);
        return w;
    endfunction

    // new random bundles for all stages
    task automatic drive_random();
        ren_bundle_t [REN_W-1:0] r;
        iss_bundle_t [ISS_W-1:0] q;
        exe_bundle_t [EXE_W-1:0] e;
        com_bundle_t             c;
        for (int i = 0; i < REN_W; i++) begin
            r[i].valid  = ($random(seed) & 3) != 0;  // mostly valid
            r[i].prs[0] = rand_preg();
            r[i].prs[1] = rand_preg();
            r[i].prd    = rand_preg();
        end
        for (int i = 0; i < ISS_W; i++) begin
            q[i].valid  = ($random(seed) & 3) != 0;
            q[i].prs[0] = rand_preg();
            q[i].prs[1] = rand_preg();
        end
        for (int k = 0; k < EXE_W; k++) begin
            e[k].valid = ($random(seed) & 1) != 0;
            e[k].exc   = ($random(seed) & 7) == 0;   // occasional fault
            e[k].prd   = rand_preg();
            e[k].data  = rand_word();
        end
        c.redir = ($random(seed) & 63) == 0;         // rare redirect
        ren <= r;
        iss <= q;
        exe <= e;
        com <= c;
    endtask

    // busy answer for one rename slot from the model
    function automatic busy_pair_t expect_busy(int slot);
        busy_pair_t b;
        preg_t      src;
        for (int s = 0; s < SRC_N; s++) begin
            src  = ren[slot].prs[s];
            b[s] = model_busy[src];
            for (int j = 0; j < slot; j++) begin
                if (ren[j].valid && ren[j].prd == src) begin
                    b[s] = 1'b1;                     // older slot of the group
                end
            end
            for (int k = 0; k < EXE_W; k++) begin
                if (exe[k].valid && exe[k].prd == src) begin
                    b[s] = 1'b0;                     // result arrives now
                end
            end
            if (src == '0) begin
                b[s] = 1'b0;
            end
        end
        return b;
    endfunction

    // operand values for one issue slot, with write-back bypass
    function automatic opnd_pair_t expect_opnd(int slot);
        opnd_pair_t o;
        preg_t      src;
        for (int s = 0; s < SRC_N; s++) begin
            src  = iss[slot].prs[s];
            o[s] = model_reg[src];
            for (int k = 0; k < EXE_W; k++) begin
                if (exe[k].valid && !exe[k].exc && exe[k].prd == src) begin
                    o[s] = exe[k].data;              // higher port last
                end
            end
            if (src == '0) begin
                o[s] = '0;
            end
        end
        return o;
    endfunction

    task automatic compare_all(int n);
        for (int i = 0; i < REN_W; i++) begin
            if (ren[i].valid) begin
                check_busy($sformatf("busy ren%0d cycle %0d", i, n),
                           expect_busy(i), busy_resp[i]);
            end
        end
        for (int i = 0; i < ISS_W; i++) begin
            if (iss[i].valid) begin
                check_opnd($sformatf("operand iss%0d cycle %0d", i, n),
                           expect_opnd(i), opnd_resp[i]);
            end
        end
    endtask

    // state the DUT takes on at the coming edge
    task automatic update_model();
        if (com.redir) begin
            for (int a = 0; a < PR_NUM; a++) begin
                model_busy[a] = 1'b0;
            end
        end else begin
            for (int i = 0; i < REN_W; i++) begin
                if (ren[i].valid && ren[i].prd != '0) begin
                    model_busy[ren[i].prd] = 1'b1;
                end
            end
            for (int k = 0; k < EXE_W; k++) begin
                if (exe[k].valid) begin
                    model_busy[exe[k].prd] = 1'b0;   // faulted ones too
                end
            end
        end
        for (int k = 0; k < EXE_W; k++) begin
            if (exe[k].valid && !exe[k].exc && exe[k].prd != '0) begin
                model_reg[exe[k].prd] = exe[k].data;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            abort_run($sformatf("timeout: run did not end within %0d cycles", TIMEOUT));
        end
    end

    initial begin
        seed  = 4;
        rst_n = 1'b0;
        ren   = '0;
        iss   = '0;
        exe   = '0;
        com   = '0;
        for (int a = 0; a < PR_NUM; a++) begin
            model_busy[a] = 1'b0;
            model_reg[a]  = '0;
        end
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;

        for (int n = 0; n < RUN_CYC; n++) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);                          // inputs settled
            compare_all(n);
            if (prf_i.prf_assert_i.fail_cnt != 0) begin
                abort_run($sformatf("a bound assertion failed before cycle %0d", n));
            end
            update_model();
        end
        @(negedge clk);                              // last inputs sampled by the checks

        if (prf_i.prf_assert_i.fail_cnt != 0) begin
            abort_run($sformatf("%0d bound assertion failures",
                                prf_i.prf_assert_i.fail_cnt));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule : tb_prf

`default_nettype wire

/* list.f */
hdl/prf_cfg_pkg.sv
hdl/pipe_bundle_pkg.sv
hdl/busy_table.sv
hdl/mwp_ram.sv
hdl/prf.sv
bench/prf_assert.sv
bench/tb_prf.sv

/* Bender.yml */
# Physical register file with busy table and write-back bypass.
package:
  name: prf

sources:
  # packages come first, the bundles use the sizes
  - files:
      - hdl/prf_cfg_pkg.sv
      - hdl/pipe_bundle_pkg.sv
      - hdl/busy_table.sv
      - hdl/mwp_ram.sv
      - hdl/prf.sv

  # bound checks and the random testbench
  - target: test
    files:
      - bench/prf_assert.sv
      - bench/tb_prf.sv

# top level of the design is prf
# top level of the simulation is tb_prf
